// File: logic/egress_settings.svh
/* Build-time sizes for the egress router. Included by every RTL file
   that needs a port count, a bus width, a buffer depth or a counter width. */

`ifndef EGRESS_SETTINGS_SVH
`define EGRESS_SETTINGS_SVH

// Port map: 8-bit lanes on the lowest indices, 32-bit lanes above them
`define NUM_PORTS       4
`define NUM_8B_PORTS    2
`define PORT_IDX_WIDTH  2

// Input bus, one 64-bit word per cycle
`define BUS_BYTES       8

// Per-port buffering. A frame is only accepted with this much room left
`define FIFO_DEPTH      64
`define MAX_FRAME_WORDS 16
`define FREE_WIDTH      ($clog2(`FIFO_DEPTH + 1))

`define CNT_WIDTH       16

`endif

// File: logic/egress_pkg.sv
/* Shared types of the egress router. */

`include "egress_settings.svh"

package egress_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus word
    //
    // The 8-bit serializers step through the byte view and the 32-bit
    // serializers through the lane view. Byte 0 is the first byte on the
    // wire, so it sits in bits 7:0 and in the low half of lane 0.
    ////////////////////////////////////////////////////////////////////////////

    typedef union packed {
        logic [`BUS_BYTES-1:0][7:0]      bytes;
        logic [`BUS_BYTES/4-1:0][31:0]   words32;
    } bus_word_u;

endpackage

// File: logic/egress_word_if.sv
/* Word channel between the demux, the port buffers and the serializers.
   A word moves on a clock edge where valid and ready are both high. */

`include "egress_settings.svh"

interface egress_word_if;
    import egress_pkg::*;

    bus_word_u             word;
    logic [`BUS_BYTES-1:0] keep;
    logic                  last;
    logic                  valid;
    logic                  ready;

    // Sending side holds word and valid until the word moves
    modport producer (
        output word,
        output keep,
        output last,
        output valid,
        input  ready
    );

    modport consumer (
        input  word,
        input  keep,
        input  last,
        input  valid,
        output ready
    );

endinterface

// File: logic/egress_demux.sv
/* Steers input frames to the port buffers. Takes the accept or drop
   decision on the first word and applies it to the whole frame. */

`include "egress_settings.svh"

module egress_demux (
    input  logic                                    core_clk_ifc,
    input  logic                                    reset,
    input  logic                                    in_valid,
    input  egress_pkg::bus_word_u                   in_data,
    input  logic [`BUS_BYTES-1:0]                   in_keep,
    input  logic                                    in_last,
    input  logic [`PORT_IDX_WIDTH-1:0]              in_port,
    input  logic [`NUM_PORTS-1:0]                   port_enable,
    input  logic [`NUM_PORTS-1:0][`FREE_WIDTH-1:0]  free_words,
    output logic [`NUM_PORTS-1:0]                   buf_full_drop,
    egress_word_if.producer                         to_buf [`NUM_PORTS]
);
    import egress_pkg::*;

    // Frame state, latched on the first word
    logic                        in_frame;
    logic [`PORT_IDX_WIDTH-1:0]  cur_port;
    logic                        cur_accept;

    logic                        first_word;
    logic                        first_room;
    logic                        first_accept;
    logic [`PORT_IDX_WIDTH-1:0]  sel_port;
    logic                        sel_accept;

    // Output register, shared payload and one valid per port
    logic [`NUM_PORTS-1:0]       wr_valid;
    bus_word_u                   wr_word;
    logic [`BUS_BYTES-1:0]       wr_keep;
    logic                        wr_last;

    assign first_word = in_valid && !in_frame;

    // A word still sitting in the output register has not reached the
    // buffer count yet, so it is taken off the room here
    assign first_room = int'(free_words[in_port]) >=
                        `MAX_FRAME_WORDS + int'(wr_valid[in_port]);

    assign first_accept = port_enable[in_port] && first_room;

    assign sel_port   = in_frame ? cur_port : in_port;
    assign sel_accept = in_frame ? cur_accept : first_accept;

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            in_frame      <= 1'b0;
            cur_port      <= '0;
            cur_accept    <= 1'b0;
            wr_valid      <= '0;
            buf_full_drop <= '0;
        end else begin
            wr_valid      <= '0;
            buf_full_drop <= '0;
            if (in_valid) begin
                in_frame <= !in_last;
                if (first_word) begin
                    cur_port   <= in_port;
                    cur_accept <= first_accept;
                    // Disabled ports discard silently, only a full buffer reports
                    buf_full_drop[in_port] <= port_enable[in_port] && !first_room;
                end
                if (sel_accept) begin
                    wr_valid[sel_port] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            wr_word <= in_data;
            wr_keep <= in_keep;
            wr_last <= in_last;
        end
    end

    // Every buffer sees the same payload, only the selected one gets valid
    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_to_buf
        assign to_buf[p].word  = wr_word;
        assign to_buf[p].keep  = wr_keep;
        assign to_buf[p].last  = wr_last;
        assign to_buf[p].valid = wr_valid[p];
    end

endmodule

// File: logic/frame_fifo.sv
/* Word buffer for one egress port with a registered read stage.
   Reports its free space to the demux for the frame accept decision. */

`include "egress_settings.svh"

module frame_fifo (
    input  logic                    core_clk_ifc,
    input  logic                    reset,
    egress_word_if.consumer         wr,
    egress_word_if.producer         rd,
    output logic [`FREE_WIDTH-1:0]  free_words
);
    import egress_pkg::*;

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);
    localparam int FREE_W = `FREE_WIDTH;

    // Storage
    bus_word_u              mem_word [`FIFO_DEPTH];
    logic [`BUS_BYTES-1:0]  mem_keep [`FIFO_DEPTH];
    logic                   mem_last [`FIFO_DEPTH];

    logic [ADDR_W-1:0]      wr_ptr;
    logic [ADDR_W-1:0]      rd_ptr;
    logic [FREE_W-1:0]      count;
    logic                   push;
    logic                   pop;

    // Read stage
    logic                   stage_valid;
    bus_word_u              stage_word;
    logic [`BUS_BYTES-1:0]  stage_keep;
    logic                   stage_last;

    assign wr.ready = count != FREE_W'(`FIFO_DEPTH);
    assign push     = wr.valid && wr.ready;

    // Refill the read stage whenever it is empty or being emptied
    assign pop = (count != '0) && (!stage_valid || rd.ready);

    // Word in the read stage still counts as used
    assign free_words = FREE_W'(`FIFO_DEPTH) - count - FREE_W'(stage_valid);

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            stage_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FREE_W'(push) - FREE_W'(pop);
            if (pop) begin
                stage_valid <= 1'b1;
            end else if (rd.ready) begin
                stage_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            mem_word[wr_ptr] <= wr.word;
            mem_keep[wr_ptr] <= wr.keep;
            mem_last[wr_ptr] <= wr.last;
        end
        if (pop) begin
            stage_word <= mem_word[rd_ptr];
            stage_keep <= mem_keep[rd_ptr];
            stage_last <= mem_last[rd_ptr];
        end
    end

    assign rd.valid = stage_valid;
    assign rd.word  = stage_word;
    assign rd.keep  = stage_keep;
    assign rd.last  = stage_last;

endmodule

// File: logic/lane_serializer.sv
/* Width serializer for one egress port. Breaks buffered 64-bit words
   into 1-byte or 4-byte lanes with a valid/ready handshake toward the sink. */

`include "egress_settings.svh"

module lane_serializer #(
    parameter int LANE_BYTES = 1
) (
    input  logic                     core_clk_ifc,
    input  logic                     reset,
    egress_word_if.consumer          from_buf,
    output logic [8*LANE_BYTES-1:0]  lane_data,
    output logic [LANE_BYTES-1:0]    lane_keep,
    output logic                     lane_valid,
    output logic                     lane_last,
    input  logic                     lane_ready
);
    import egress_pkg::*;

    localparam int NUM_LANES = `BUS_BYTES / LANE_BYTES;
    localparam int IDX_W     = $clog2(NUM_LANES);

    // Word being serialized
    logic                   hold_valid;
    bus_word_u              hold_word;
    logic [`BUS_BYTES-1:0]  hold_keep;
    logic                   hold_last;
    logic [IDX_W-1:0]       lane_idx;

    logic [`BUS_BYTES-1:0]  keep_rest;
    logic                   final_lane;
    logic                   lane_move;
    logic                   load;

    ////////////////////////////////////////////////////////////////////////////
    // Lane selection
    ////////////////////////////////////////////////////////////////////////////

    // Keep bits from the current lane upward
    assign keep_rest = hold_keep >> (lane_idx * LANE_BYTES);
    assign lane_keep = keep_rest[LANE_BYTES-1:0];

    // Keep is contiguous from byte 0, so an empty next lane means every
    // lane above it is empty too and the word is done
    assign final_lane = keep_rest[2*LANE_BYTES-1:LANE_BYTES] == '0;

    if (LANE_BYTES == 1) begin : g_byte_lane
        assign lane_data = hold_word.bytes[lane_idx];
    end else begin : g_word_lane
        assign lane_data = hold_word.words32[lane_idx];
    end

    assign lane_valid = hold_valid;
    assign lane_last  = hold_valid && hold_last && final_lane;

    ////////////////////////////////////////////////////////////////////////////
    // Word hand-off
    ////////////////////////////////////////////////////////////////////////////

    assign lane_move = hold_valid && lane_ready;

    // Next word comes in on the same edge the final lane leaves
    assign from_buf.ready = !hold_valid || (lane_move && final_lane);
    assign load           = from_buf.valid && from_buf.ready;

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            hold_valid <= 1'b0;
            lane_idx   <= '0;
        end else if (load) begin
            hold_valid <= 1'b1;
            lane_idx   <= '0;
        end else if (lane_move) begin
            if (final_lane) begin
                hold_valid <= 1'b0;
            end else begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (load) begin
            hold_word <= from_buf.word;
            hold_keep <= from_buf.keep;
            hold_last <= from_buf.last;
        end
    end

endmodule

// File: logic/frame_counters.sv
/* Per-port counters of frames that left the router, with a per-port
   clear. Counters stick at their maximum value. */

`include "egress_settings.svh"

module frame_counters (
    input  logic                                   core_clk_ifc,
    input  logic                                   reset,
    input  logic [`NUM_PORTS-1:0]                  frame_done,
    input  logic [`NUM_PORTS-1:0]                  cnt_clear,
    output logic [`NUM_PORTS-1:0][`CNT_WIDTH-1:0]  frame_cnt
);

    logic [`NUM_PORTS-1:0] at_max;

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_max
        assign at_max[p] = &frame_cnt[p];
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            frame_cnt <= '0;
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                // Clear wins over a frame finishing in the same cycle
                if (cnt_clear[p]) begin
                    frame_cnt[p] <= '0;
                end else if (frame_done[p] && !at_max[p]) begin
                    frame_cnt[p] <= frame_cnt[p] + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/egress_top.sv
/* Egress side of the packet router. One 64-bit frame bus in, two 8-bit
   and two 32-bit egress ports out, with drop flags and frame counters. */

`include "egress_settings.svh"

module egress_top (
    input  logic                                        core_clk_ifc,
    input  logic                                        reset,

    // Frame bus from the router core
    input  logic                                        in_valid,
    input  logic [8*`BUS_BYTES-1:0]                     in_data,
    input  logic [`BUS_BYTES-1:0]                       in_keep,
    input  logic                                        in_last,
    input  logic [`PORT_IDX_WIDTH-1:0]                  in_port,

    // Control and status
    input  logic [`NUM_PORTS-1:0]                       port_enable,
    input  logic [`NUM_PORTS-1:0]                       cnt_clear,
    output logic [`NUM_PORTS-1:0][`CNT_WIDTH-1:0]       frame_cnt,
    output logic [`NUM_PORTS-1:0]                       buf_full_drop,

    // Egress ports
    input  logic [`NUM_PORTS-1:0]                       out_ready,
    output logic [`NUM_PORTS-1:0]                       out_valid,
    output logic [`NUM_PORTS-1:0]                       out_last,
    output logic [`NUM_8B_PORTS-1:0][7:0]               out_data_8b,
    output logic [`NUM_PORTS-`NUM_8B_PORTS-1:0][31:0]   out_data_32b,
    output logic [`NUM_PORTS-`NUM_8B_PORTS-1:0][3:0]    out_keep_32b
);

    logic [`NUM_PORTS-1:0][`FREE_WIDTH-1:0] free_words;
    logic [`NUM_PORTS-1:0]                  frame_done;

    egress_word_if to_buf [`NUM_PORTS] ();
    egress_word_if to_ser [`NUM_PORTS] ();

    ////////////////////////////////////////////////////////////////////////////
    // Demux and port buffers
    ////////////////////////////////////////////////////////////////////////////

    egress_demux u_demux (
        .core_clk_ifc  (core_clk_ifc),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_port       (in_port),
        .port_enable   (port_enable),
        .free_words    (free_words),
        .buf_full_drop (buf_full_drop),
        .to_buf        (to_buf)
    );

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_buf
        frame_fifo u_fifo (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .wr           (to_buf[p]),
            .rd           (to_ser[p]),
            .free_words   (free_words[p])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Serializers, 8-bit ports first
    ////////////////////////////////////////////////////////////////////////////

    for (genvar p = 0; p < `NUM_8B_PORTS; p++) begin : g_ser_8b
        lane_serializer #(
            .LANE_BYTES (1)
        ) u_ser (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .from_buf     (to_ser[p]),
            .lane_data    (out_data_8b[p]),
            .lane_keep    (),
            .lane_valid   (out_valid[p]),
            .lane_last    (out_last[p]),
            .lane_ready   (out_ready[p])
        );
    end

    for (genvar p = 0; p < `NUM_PORTS - `NUM_8B_PORTS; p++) begin : g_ser_32b
        lane_serializer #(
            .LANE_BYTES (4)
        ) u_ser (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .from_buf     (to_ser[p + `NUM_8B_PORTS]),
            .lane_data    (out_data_32b[p]),
            .lane_keep    (out_keep_32b[p]),
            .lane_valid   (out_valid[p + `NUM_8B_PORTS]),
            .lane_last    (out_last[p + `NUM_8B_PORTS]),
            .lane_ready   (out_ready[p + `NUM_8B_PORTS])
        );
    end

    // A frame is done when its final lane is taken by the sink
    assign frame_done = out_valid & out_ready & out_last;

    frame_counters u_counters (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .frame_done   (frame_done),
        .cnt_clear    (cnt_clear),
        .frame_cnt    (frame_cnt)
    );

endmodule

// File: bench/egress_props.sv
/* Assertions on the egress port handshake and on reset values.
   Bound into egress_top by the testbench. */

`include "egress_settings.svh"

module egress_props (
    input logic                                      core_clk_ifc,
    input logic                                      reset,
    input logic [`NUM_PORTS-1:0]                     out_valid,
    input logic [`NUM_PORTS-1:0]                     out_ready,
    input logic [`NUM_PORTS-1:0]                     out_last,
    input logic [`NUM_PORTS-1:0]                     buf_full_drop,
    input logic [`NUM_8B_PORTS-1:0][7:0]             out_data_8b,
    input logic [`NUM_PORTS-`NUM_8B_PORTS-1:0][31:0] out_data_32b,
    input logic [`NUM_PORTS-`NUM_8B_PORTS-1:0][3:0]  out_keep_32b
);

    // Outputs are quiet on the edge after reset has been seen
    a_reset_quiet: assert property (@(posedge core_clk_ifc)
        reset |=> (out_valid == '0) && (buf_full_drop == '0))
        else $error("output active during reset");

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_hold
        a_hold: assert property (@(posedge core_clk_ifc) disable iff (reset)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_last[p]))
            else $error("lane valid or last changed while stalled");
    end

    for (genvar p = 0; p < `NUM_8B_PORTS; p++) begin : g_hold_8b
        a_data: assert property (@(posedge core_clk_ifc) disable iff (reset)
            out_valid[p] && !out_ready[p] |=> $stable(out_data_8b[p]))
            else $error("8-bit lane data changed while stalled");
    end

    for (genvar p = 0; p < `NUM_PORTS - `NUM_8B_PORTS; p++) begin : g_hold_32b
        a_data: assert property (@(posedge core_clk_ifc) disable iff (reset)
            out_valid[p + `NUM_8B_PORTS] && !out_ready[p + `NUM_8B_PORTS]
            |=> $stable(out_data_32b[p]) && $stable(out_keep_32b[p]))
            else $error("32-bit lane data changed while stalled");
    end

endmodule

bind egress_top egress_props u_props (.*);

// File: bench/egress_tb.sv
/* Testbench for the egress router. Reads test steps from the case file,
   drives frames on the falling edge and checks every lane, drop flag and count. */

`include "egress_settings.svh"

module egress_tb;

    localparam int MAX_CYCLES = 4000;
    localparam int HELD       = 2;
    localparam int RANDOM     = 1;

    logic                                   core_clk_ifc;
    logic                                   reset;
    logic                                   in_valid;
    logic [8*`BUS_BYTES-1:0]                in_data;
    logic [`BUS_BYTES-1:0]                  in_keep;
    logic                                   in_last;
    logic [`PORT_IDX_WIDTH-1:0]             in_port;
    logic [`NUM_PORTS-1:0]                  port_enable;
    logic [`NUM_PORTS-1:0]                  cnt_clear;
    logic [`NUM_PORTS-1:0][`CNT_WIDTH-1:0]  frame_cnt;
    logic [`NUM_PORTS-1:0]                  buf_full_drop;
    logic [`NUM_PORTS-1:0]                  out_ready;
    logic [`NUM_PORTS-1:0]                  out_valid;
    logic [`NUM_PORTS-1:0]                  out_last;
    logic [`NUM_8B_PORTS-1:0][7:0]          out_data_8b;
    logic [`NUM_PORTS-`NUM_8B_PORTS-1:0][31:0] out_data_32b;
    logic [`NUM_PORTS-`NUM_8B_PORTS-1:0][3:0]  out_keep_32b;

    // Reference model state
    logic [7:0]            exp_bytes [`NUM_PORTS][$];
    logic                  exp_lasts [`NUM_PORTS][$];
    logic [`CNT_WIDTH-1:0] exp_cnt   [`NUM_PORTS];
    int                    free_model [`NUM_PORTS];
    int                    ready_mode [`NUM_PORTS];
    integer                seed;
    int                    cycles;

    egress_top UUT (.*);

    initial core_clk_ifc = 1'b0;
    always #20 core_clk_ifc = ~core_clk_ifc;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input logic [7:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_lane32(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_keep(input string name, input logic [3:0] exp,
                              input logic [3:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [`CNT_WIDTH-1:0] exp,
                               input logic [`CNT_WIDTH-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %0d actual %0d",
                               $time, name, exp, act));
        end
    endtask

    // Drop flags, one bit per port
    task automatic check_flags(input string name, input logic [`NUM_PORTS-1:0] exp,
                               input logic [`NUM_PORTS-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    always @(posedge core_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run("Timeout: the case list did not finish within the cycle limit");
        end
    end

    task automatic take_lane(input int p);
        logic [31:0] exp_data;
        logic [3:0]  exp_keep;
        logic        exp_last;
        int          n;
        exp_data = '0;
        exp_keep = '0;
        exp_last = 1'b0;
        n = 0;
        if (exp_bytes[p].size() == 0) begin
            fail_run($sformatf("Port %0d sent a lane while no frame was expected", p));
        end else if (p < `NUM_8B_PORTS) begin
            exp_data[7:0] = exp_bytes[p].pop_front();
            exp_last = exp_lasts[p].pop_front();
            check_byte($sformatf("out_data_8b[%0d]", p), exp_data[7:0], out_data_8b[p]);
            check_last($sformatf("out_last[%0d]", p), exp_last, out_last[p]);
        end else begin
            // Lanes restart at each frame, since frames begin on a word boundary
            while (n < 4 && !exp_last && exp_bytes[p].size() > 0) begin
                exp_data[8*n +: 8] = exp_bytes[p].pop_front();
                exp_last = exp_lasts[p].pop_front();
                exp_keep[n] = 1'b1;
                n++;
            end
            check_lane32($sformatf("out_data_32b[%0d]", p - `NUM_8B_PORTS), exp_data,
                         out_data_32b[p - `NUM_8B_PORTS]);
            check_keep($sformatf("out_keep_32b[%0d]", p - `NUM_8B_PORTS), exp_keep,
                       out_keep_32b[p - `NUM_8B_PORTS]);
            check_last($sformatf("out_last[%0d]", p), exp_last, out_last[p]);
        end
    endtask

    // Sink side of each port, one draw per cycle in random mode.
    // Lane outputs come straight from registers, so the lane that the
    // next rising edge takes is already stable here
    always @(negedge core_clk_ifc) begin
        logic rdy;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (ready_mode[p] == HELD) begin
                rdy = 1'b0;
            end else if (ready_mode[p] == RANDOM) begin
                rdy = 1'($random(seed));
            end else begin
                rdy = 1'b1;
            end
            out_ready[p] <= rdy;
            if (!reset && out_valid[p] && rdy) begin
                take_lane(p);
            end
        end
    end

    task automatic next_cycle(input logic [`NUM_PORTS-1:0] exp_drop);
        @(negedge core_clk_ifc);
        check_flags("buf_full_drop", exp_drop, buf_full_drop);
    endtask

    task automatic send_frame(input int port, input int len);
        logic [`NUM_PORTS-1:0] drop_mask;
        logic [7:0]            b;
        int                    nwords;
        int                    idx;
        logic                  room;
        logic                  accept;
        nwords = (len + 7) / 8;
        room = (ready_mode[port] != HELD) || (free_model[port] >= `MAX_FRAME_WORDS);
        accept = port_enable[port] && room;
        drop_mask = '0;
        drop_mask[port] = port_enable[port] && !room;
        if (accept) begin
            exp_cnt[port] = exp_cnt[port] + 1'b1;
            if (ready_mode[port] == HELD) begin
                free_model[port] -= nwords;
            end
        end
        for (int w = 0; w < nwords; w++) begin
            if (w > 0) begin
                next_cycle(w == 1 ? drop_mask : '0);
            end
            in_data = '0;
            in_keep = '0;
            for (int k = 0; k < `BUS_BYTES; k++) begin
                idx = 8 * w + k;
                if (idx < len) begin
                    b = 8'($random(seed));
                    in_data[8*k +: 8] = b;
                    in_keep[k] = 1'b1;
                    if (accept) begin
                        exp_bytes[port].push_back(b);
                        exp_lasts[port].push_back(idx == len - 1);
                    end
                end
            end
            in_valid = 1'b1;
            in_port = `PORT_IDX_WIDTH'(port);
            in_last = (w == nwords - 1);
        end
        next_cycle(nwords == 1 ? drop_mask : '0);
        in_valid = 1'b0;
        in_last = 1'b0;
    endtask

    function automatic logic pending();
        logic any;
        any = 1'b0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            any |= (exp_bytes[p].size() > 0);
        end
        return any;
    endfunction

    task automatic check_counts();
        while (pending()) begin
            next_cycle('0);
        end
        next_cycle('0);
        for (int p = 0; p < `NUM_PORTS; p++) begin
            check_count($sformatf("frame_cnt[%0d]", p), exp_cnt[p], frame_cnt[p]);
        end
    endtask

    task automatic run_step(input string cmd, input int port, input int len,
                            input logic [`NUM_PORTS-1:0] mask, input string mode);
        ready_mode[port] = (mode == "h") ? HELD : (mode == "r") ? RANDOM : 0;
        if (ready_mode[port] != HELD) begin
            free_model[port] = `FIFO_DEPTH;
        end
        port_enable = mask;
        if (cmd == "frame") begin
            send_frame(port, len);
        end else if (cmd == "wait") begin
            repeat (len) next_cycle('0);
        end else if (cmd == "clear") begin
            cnt_clear[port] = 1'b1;
            next_cycle('0);
            cnt_clear = '0;
            exp_cnt[port] = '0;
        end else if (cmd == "check") begin
            check_counts();
        end else begin
            fail_run($sformatf("Unknown command %s in the case file", cmd));
        end
    endtask

    initial begin
        integer fd;
        integer n;
        string  line;
        string  cmd;
        string  mode;
        int     port;
        int     len;
        logic [`NUM_PORTS-1:0] mask;
        seed = 32'h2b54f874;
        cycles = 0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_port = '0;
        port_enable = '1;
        cnt_clear = '0;
        out_ready = '1;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            exp_cnt[p] = '0;
            free_model[p] = `FIFO_DEPTH;
            ready_mode[p] = 0;
        end
        repeat (2) @(negedge core_clk_ifc);
        reset = 1'b0;
        fd = $fopen("bench/egress_cases.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the case file bench/egress_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %d %d %h %s", cmd, port, len, mask, mode);
                // Comment and blank lines do not parse into five fields
                if (n == 5) begin
                    run_step(cmd, port, len, mask, mode);
                end
            end
            $fclose(fd);
            check_counts();
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: bench/egress_cases.txt
# command port bytes enable_mask(hex) ready(a=always r=random h=held low)
# frame sends one frame, wait idles for bytes cycles, clear and check act on counters
frame 0 13 f a
frame 1 8 f a
frame 2 37 f a
frame 3 5 f a
frame 2 128 f a
frame 1 1 f a
check 0 0 f a
frame 1 20 d a
frame 1 64 d a
check 1 0 d a
frame 3 128 f h
frame 3 128 f h
frame 3 128 f h
frame 3 128 f h
frame 3 128 f h
frame 3 128 f h
wait 3 30 f h
check 3 0 f a
frame 0 40 f r
frame 2 60 f r
wait 0 60 f r
frame 0 17 f r
frame 3 99 f r
wait 2 60 f r
frame 2 7 f r
check 0 0 f a
clear 2 0 f a
check 2 0 f a

// File: sources.f
+incdir+logic
logic/egress_pkg.sv
logic/egress_word_if.sv
logic/egress_demux.sv
logic/frame_fifo.sv
logic/lane_serializer.sv
logic/frame_counters.sv
logic/egress_top.sv
bench/egress_props.sv
bench/egress_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := egress_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/egress_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) bench/egress_cases.txt
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
